//--- all.f
logic/cpuPkg.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/addressRegisters.sv
logic/arithmeticUnit.sv
logic/programMemory.sv
logic/cpuSystem.sv
dv/cpuSystem_properties.sv
dv/cpuSystemTb.sv

//--- dv/cpuSystemTb.sv
`timescale 1ns/1ps

module cpuSystemTb;
    import cpuPkg::*;

    localparam int DataWidth = 16;
    localparam int RunCycles = 150;
    localparam int TimeoutCycles = 3000;  // Five tests, each well under 250 cycles
    localparam logic [5:0] OpBra = 6'h00;
    localparam logic [5:0] OpBne = 6'h01;
    localparam logic [5:0] OpBeq = 6'h02;
    localparam logic [5:0] OpInc = 6'h09;
    localparam logic [5:0] OpDec = 6'h0A;
    localparam logic [5:0] OpAdd = 6'h15;
    localparam logic [5:0] OpMov = 6'h18;
    localparam logic [5:0] OpMovl = 6'h19;
    localparam logic [5:0] OpStar = 6'h1D;
    localparam logic [5:0] OpLdal = 6'h1E;
    localparam logic [5:0] OpSta = 6'h20;

    logic    Clock;
    logic    Reset;
    logic    Run;
    logic    LoadWrite;
    addressT LoadAddress;
    byteT    LoadData;
    byteT    LoadReadData;

    integer      seed = 83;
    int          cycleCount = 0;
    int          testErrors = 0;
    int          passCount = 0;
    int          failCount = 0;
    logic [15:0] programWords [$];

    cpuSystem #(.DataWidth(DataWidth)) uut (
        .Clock(Clock), .Reset(Reset), .Run(Run), .LoadWrite(LoadWrite),
        .LoadAddress(LoadAddress), .LoadData(LoadData), .LoadReadData(LoadReadData)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Opcode, Rx and 8-bit immediate or address
    function automatic logic [15:0] immediateWord(input logic [5:0] op, input logic [1:0] rx,
                                                  input logic [7:0] value);
        return {op, rx, value};
    endfunction

    function automatic logic [15:0] registerWord(input logic [5:0] op, input logic [2:0] dest,
                                                 input logic [2:0] srcA, input logic [2:0] srcB);
        return {op, dest, srcA, srcB, 1'b0};
    endfunction

    task automatic applyReset();
        @(posedge Clock);
        Reset <= 1'b0;
        Run <= 1'b0;
        repeat (8) @(posedge Clock);
        Reset <= 1'b1;
    endtask

    task automatic writeByte(input addressT address, input byteT data);
        @(posedge Clock);
        LoadWrite <= 1'b1;
        LoadAddress <= address;
        LoadData <= data;
        @(posedge Clock);          // Byte written at this edge
        LoadWrite <= 1'b0;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < programWords.size(); i++) begin
            writeByte(addressT'(2 * i), programWords[i][7:0]);       // Low byte first
            writeByte(addressT'(2 * i + 1), programWords[i][15:8]);
        end
        programWords.delete();
    endtask

    task automatic runProgram();
        @(posedge Clock);
        Run <= 1'b1;
        repeat (RunCycles) @(posedge Clock);
        Run <= 1'b0;
    endtask

    task automatic checkByte(input string name, input addressT address, input byteT expected);
        byteT actual;
        @(posedge Clock);
        LoadAddress <= address;
        @(negedge Clock);
        actual = LoadReadData;
        if (actual !== expected) begin
            $display("MISMATCH %s: address %h expected %h actual %h",
                     name, address, expected, actual);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("%s: ok", name);
            passCount++;
        end else begin
            $display("%s: %0d errors", name, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    task automatic loadPortReadback();
        addressT addresses [8];
        byteT    shadow [256];
        applyReset();
        for (int i = 0; i < 8; i++) begin
            addresses[i] = addressT'($random(seed));
            shadow[addresses[i]] = byteT'($random(seed));  // Repeated address keeps last byte
            writeByte(addresses[i], shadow[addresses[i]]);
        end
        for (int i = 0; i < 8; i++) begin
            checkByte("loadPortReadback", addresses[i], shadow[addresses[i]]);
        end
        finishTest("loadPortReadback");
    endtask

    task automatic immediateStore();
        applyReset();
        programWords.push_back(immediateWord(OpMovl, 2'd0, 8'h5C));
        programWords.push_back(immediateWord(OpSta, 2'd0, 8'h80));
        programWords.push_back(immediateWord(OpBra, 2'd0, 8'h04));
        loadProgram();
        writeByte(8'h80, 8'h00);
        runProgram();
        checkByte("immediateStore", 8'h80, 8'h5C);
        finishTest("immediateStore");
    endtask

    task automatic aluChain();
        logic [DataWidth-1:0] r1;
        logic [DataWidth-1:0] r2;
        logic [DataWidth-1:0] r3;
        logic [DataWidth-1:0] r4;
        applyReset();
        programWords.push_back(immediateWord(OpMovl, 2'd0, 8'hF0));
        programWords.push_back(immediateWord(OpMovl, 2'd1, 8'h25));
        programWords.push_back(registerWord(OpAdd, 3'd6, 3'd4, 3'd5));  // R3 = R1 + R2
        programWords.push_back(immediateWord(OpSta, 2'd2, 8'h90));
        programWords.push_back(registerWord(OpInc, 3'd7, 3'd6, 3'd0));  // R4 = R3 + 1
        programWords.push_back(immediateWord(OpSta, 2'd3, 8'h91));
        programWords.push_back(registerWord(OpDec, 3'd4, 3'd4, 3'd0));
        programWords.push_back(immediateWord(OpSta, 2'd0, 8'h92));
        programWords.push_back(registerWord(OpMov, 3'd5, 3'd7, 3'd0));  // R2 = R4
        programWords.push_back(immediateWord(OpSta, 2'd1, 8'h93));
        programWords.push_back(immediateWord(OpBra, 2'd0, 8'h14));
        loadProgram();
        runProgram();
        r1 = DataWidth'(8'hF0);
        r2 = DataWidth'(8'h25);
        r3 = r1 + r2;
        r4 = r3 + DataWidth'(1);
        r1 = r1 - DataWidth'(1);
        r2 = r4;
        checkByte("aluChain", 8'h90, r3[7:0]);
        checkByte("aluChain", 8'h91, r4[7:0]);
        checkByte("aluChain", 8'h92, r1[7:0]);
        checkByte("aluChain", 8'h93, r2[7:0]);
        finishTest("aluChain");
    endtask

    task automatic branchLoop();
        byteT loopCount;
        applyReset();
        loopCount = 8'd3;
        programWords.push_back(immediateWord(OpMovl, 2'd0, loopCount));
        programWords.push_back(immediateWord(OpMovl, 2'd2, 8'hEE));     // Marker in R3
        programWords.push_back(registerWord(OpInc, 3'd5, 3'd5, 3'd0));  // Loop head at 04h
        programWords.push_back(registerWord(OpDec, 3'd4, 3'd4, 3'd0));
        programWords.push_back(immediateWord(OpBne, 2'd0, 8'h04));
        programWords.push_back(immediateWord(OpSta, 2'd1, 8'hA0));
        programWords.push_back(immediateWord(OpBeq, 2'd0, 8'h10));      // Skips the marker store
        programWords.push_back(immediateWord(OpSta, 2'd2, 8'hA1));
        programWords.push_back(immediateWord(OpBra, 2'd0, 8'h10));
        loadProgram();
        writeByte(8'hA0, 8'h00);
        writeByte(8'hA1, 8'h00);
        runProgram();
        checkByte("branchLoop", 8'hA0, loopCount);
        checkByte("branchLoop", 8'hA1, 8'h00);
        finishTest("branchLoop");
    endtask

    task automatic indirectStore();
        byteT dataByte;
        byteT target;
        applyReset();
        dataByte = 8'hB3;
        target = dataByte + 8'd1;  // Incremented byte becomes the AR address
        programWords.push_back(immediateWord(OpLdal, 2'd0, 8'h60));
        programWords.push_back(registerWord(OpInc, 3'd5, 3'd4, 3'd0));
        programWords.push_back(registerWord(OpMov, 3'd2, 3'd5, 3'd0));  // AR = R2
        programWords.push_back(immediateWord(OpMovl, 2'd3, 8'h3C));
        programWords.push_back(registerWord(OpStar, 3'd0, 3'd7, 3'd0));
        programWords.push_back(immediateWord(OpBra, 2'd0, 8'h0A));
        loadProgram();
        writeByte(8'h60, dataByte);
        writeByte(target, 8'h00);
        runProgram();
        checkByte("indirectStore", target, 8'h3C);
        finishTest("indirectStore");
    endtask

    initial begin
        Reset = 1'b0;
        Run = 1'b0;
        LoadWrite = 1'b0;
        LoadAddress = '0;
        LoadData = '0;
        loadPortReadback();
        immediateStore();
        aluChain();
        branchLoop();
        indirectStore();
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- dv/cpuSystem_properties.sv
`timescale 1ns/1ps

module controlUnitProperties (
    input logic              Clock,
    input logic              Reset,
    input logic              Run,
    input cpuPkg::cpuStateE  State,
    input cpuPkg::regOneHotT RfWrite,
    input logic              WriteFlags,
    input logic              PcIncrement,
    input logic              PcLoad,
    input logic              ArLoad,
    input logic              MemWrite
);
    import cpuPkg::*;

    storeOnlyInExecute: assert property (@(posedge Clock) disable iff (!Reset)
        (State != Execute) |-> !MemWrite)
        else $error("MemWrite high during a fetch cycle");

    legalState: assert property (@(posedge Clock) disable iff (!Reset)
        State inside {FetchLsb, FetchMsb, Execute})
        else $error("FSM left its three legal states");

    // Idle processor keeps every strobe low
    quietWhileIdle: assert property (@(posedge Clock) disable iff (!Reset)
        !Run |-> (RfWrite == '0) && !WriteFlags && !PcIncrement && !PcLoad && !ArLoad
                 && !MemWrite)
        else $error("Strobe raised while Run is low");

endmodule

bind controlUnit controlUnitProperties controlChecks (
    .Clock(Clock), .Reset(Reset), .Run(Run), .State(state), .RfWrite(RfWrite),
    .WriteFlags(WriteFlags), .PcIncrement(PcIncrement), .PcLoad(PcLoad),
    .ArLoad(ArLoad), .MemWrite(MemWrite)
);

//--- logic/addressRegisters.sv
`timescale 1ns/1ps

module addressRegisters (
    input  logic             Clock,
    input  logic             Reset,
    input  logic             PcIncrement,
    input  logic             PcLoad,
    input  logic             ArLoad,
    input  cpuPkg::addressT  LoadValue,
    input  cpuPkg::addrSelE  AddrSel,
    input  cpuPkg::addressT  DirectAddress,
    output cpuPkg::addressT  MemAddress
);
    import cpuPkg::*;

    addressT programCounter;
    addressT addressReg;
    addressT loadSource;

    // Branches, LDAL and STA select the direct address, so it is also what they load
    assign loadSource = (AddrSel == Direct) ? DirectAddress : LoadValue;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            programCounter <= '0;
            addressReg <= '0;
        end else begin
            if (PcLoad) begin
                programCounter <= loadSource;  // Load wins over increment
            end else if (PcIncrement) begin
                programCounter <= programCounter + addressT'(1);
            end
            if (ArLoad) begin
                addressReg <= loadSource;
            end
        end
    end

    always_comb begin
        case (AddrSel)
            Ar:      MemAddress = addressReg;
            Direct:  MemAddress = DirectAddress;
            default: MemAddress = programCounter;
        endcase
    end

endmodule

//--- logic/arithmeticUnit.sv
`timescale 1ns/1ps

module arithmeticUnit #(
    parameter int DataWidth = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  cpuPkg::aluOpE        AluOp,
    input  logic                 WriteFlags,
    input  logic [DataWidth-1:0] OperandA,
    input  logic [DataWidth-1:0] OperandB,
    output logic [DataWidth-1:0] Result,
    output logic                 Zero
);
    import cpuPkg::*;

    logic zeroFlag;

    // All operations wrap around at DataWidth
    always_comb begin
        case (AluOp)
            Add:     Result = OperandA + OperandB;
            Sub:     Result = OperandA - OperandB;
            IncA:    Result = OperandA + DataWidth'(1);
            DecA:    Result = OperandA - DataWidth'(1);
            default: Result = OperandA;  // PassA
        endcase
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            zeroFlag <= 1'b0;
        end else if (WriteFlags) begin
            zeroFlag <= (Result == '0);
        end
    end

    assign Zero = zeroFlag;  // Stored flag for BNE and BEQ

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic              Clock,
    input  logic              Reset,
    input  logic              Run,
    input  cpuPkg::byteT      MemData,
    input  logic              Zero,
    output cpuPkg::regOneHotT RfWrite,
    output cpuPkg::rfModeE    RfMode,
    output cpuPkg::rfSourceE  RfSource,
    output logic [1:0]        ReadSelA,
    output logic [1:0]        ReadSelB,
    output cpuPkg::byteT      Immediate,
    output cpuPkg::aluOpE     AluOp,
    output logic              WriteFlags,
    output logic              PcIncrement,
    output logic              PcLoad,
    output logic              ArLoad,
    output cpuPkg::addrSelE   AddrSel,
    output cpuPkg::addressT   DirectAddress,
    output logic              MemWrite
);
    import cpuPkg::*;

    cpuStateE    state;
    instructionT instruction;
    opcodeE      opcode;
    regCodeT     destCode;
    regCodeT     srcCodeA;
    regCodeT     srcCodeB;
    logic [1:0]  regSel;

    function automatic regOneHotT oneHot(input logic [1:0] sel);
        return regOneHotT'(1) << sel;
    endfunction

    assign opcode = opcodeE'(instruction[15:10]);
    assign regSel = instruction[9:8];    // Rx of MOVL, LDAL and STA
    assign destCode = instruction[9:7];
    assign srcCodeA = instruction[6:4];
    assign srcCodeB = instruction[3:1];
    assign Immediate = instruction[7:0];
    assign DirectAddress = addressT'(instruction[7:0]);

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            state <= FetchLsb;
        end else if (!Run) begin
            state <= FetchLsb;           // Idle, parked at the start of a fetch
        end else begin
            case (state)
                FetchLsb: state <= FetchMsb;
                FetchMsb: state <= Execute;
                default:  state <= FetchLsb;
            endcase
        end
    end

    // Instruction register, filled one byte per fetch cycle
    always_ff @(posedge Clock) begin
        if (Run && state == FetchLsb) begin
            instruction[7:0] <= MemData;
        end
        if (Run && state == FetchMsb) begin
            instruction[15:8] <= MemData;
        end
    end

    always_comb begin
        RfWrite = '0;
        RfMode = LoadFull;
        RfSource = cpuPkg::AluResult;
        ReadSelA = '0;
        ReadSelB = '0;
        AluOp = PassA;
        WriteFlags = 1'b0;
        PcIncrement = 1'b0;
        PcLoad = 1'b0;
        ArLoad = 1'b0;
        AddrSel = Pc;
        MemWrite = 1'b0;
        if (Run) begin
            case (state)
                FetchLsb, FetchMsb: begin
                    PcIncrement = 1'b1;  // Memory addressed by PC
                end
                Execute: begin
                    case (opcode)
                        BRA: begin
                            PcLoad = 1'b1;
                            AddrSel = Direct;   // Also picks the address field as load value
                        end
                        BNE: begin
                            PcLoad = !Zero;
                            AddrSel = Direct;
                        end
                        BEQ: begin
                            PcLoad = Zero;
                            AddrSel = Direct;
                        end
                        INC, DEC, ADD, MOV: begin
                            ReadSelA = srcCodeA[1:0];
                            ReadSelB = srcCodeB[1:0];
                            case (opcode)
                                INC:     AluOp = IncA;
                                DEC:     AluOp = DecA;
                                ADD:     AluOp = Add;
                                default: AluOp = PassA;
                            endcase
                            WriteFlags = (opcode != MOV);  // MOV leaves Z alone
                            if (destCode == 3'd0) begin
                                PcLoad = 1'b1;
                            end else if (destCode[2:1] == 2'b01) begin
                                ArLoad = 1'b1;
                            end else if (destCode[2]) begin
                                RfWrite = oneHot(destCode[1:0]);
                            end
                        end
                        MOVL: begin
                            RfWrite = oneHot(regSel);
                            RfMode = LoadLow;
                            RfSource = cpuPkg::Immediate;
                        end
                        LDAL: begin
                            AddrSel = Direct;
                            ArLoad = 1'b1;      // AR follows the address field
                            RfWrite = oneHot(regSel);
                            RfSource = cpuPkg::MemoryByte;
                        end
                        STA: begin
                            AddrSel = Direct;
                            ArLoad = 1'b1;
                            ReadSelA = regSel;  // Low byte of OutA is the store data
                            MemWrite = 1'b1;
                        end
                        STAR: begin
                            AddrSel = Ar;
                            ReadSelA = srcCodeA[1:0];
                            MemWrite = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

    localparam int AddressWidth = 8;
    localparam int ByteWidth = 8;
    localparam int InstructionWidth = 16;

    typedef logic [AddressWidth-1:0] addressT;
    typedef logic [ByteWidth-1:0] byteT;
    typedef logic [InstructionWidth-1:0] instructionT;
    typedef logic [2:0] regCodeT;    // 0 PC, 1 unused, 2 and 3 AR, 4 to 7 R1 to R4
    typedef logic [3:0] regOneHotT;  // Bit 0 is R1

    typedef enum logic [5:0] {
        BRA  = 6'h00,
        BNE  = 6'h01,
        BEQ  = 6'h02,
        INC  = 6'h09,
        DEC  = 6'h0A,
        ADD  = 6'h15,
        MOV  = 6'h18,
        MOVL = 6'h19,
        STAR = 6'h1D,
        LDAL = 6'h1E,
        STA  = 6'h20
    } opcodeE;

    typedef enum logic [1:0] {
        FetchLsb,
        FetchMsb,
        Execute
    } cpuStateE;

    typedef enum logic [2:0] {
        PassA,
        Add,
        Sub,
        IncA,
        DecA
    } aluOpE;

    typedef enum logic [1:0] {
        AluResult,
        MemoryByte,
        Immediate
    } rfSourceE;

    typedef enum logic {
        LoadFull,
        LoadLow
    } rfModeE;

    typedef enum logic [1:0] {
        Pc,
        Ar,
        Direct
    } addrSelE;

endpackage

//--- logic/cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem #(
    parameter int DataWidth = 16
) (
    input  logic            Clock,
    input  logic            Reset,
    input  logic            Run,
    input  logic            LoadWrite,
    input  cpuPkg::addressT LoadAddress,
    input  cpuPkg::byteT    LoadData,
    output cpuPkg::byteT    LoadReadData
);
    import cpuPkg::*;

    byteT                 memData;
    logic                 zero;
    regOneHotT            rfWrite;
    rfModeE               rfMode;
    rfSourceE             rfSource;
    logic [1:0]           readSelA;
    logic [1:0]           readSelB;
    byteT                 immediate;
    aluOpE                aluOp;
    logic                 writeFlags;
    logic                 pcIncrement;
    logic                 pcLoad;
    logic                 arLoad;
    addrSelE              addrSel;
    addressT              directAddress;
    logic                 memWrite;
    addressT              memAddress;
    logic [DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] outA;
    logic [DataWidth-1:0] outB;

    controlUnit control (
        .Clock(Clock), .Reset(Reset), .Run(Run), .MemData(memData), .Zero(zero),
        .RfWrite(rfWrite), .RfMode(rfMode), .RfSource(rfSource),
        .ReadSelA(readSelA), .ReadSelB(readSelB), .Immediate(immediate),
        .AluOp(aluOp), .WriteFlags(writeFlags), .PcIncrement(pcIncrement),
        .PcLoad(pcLoad), .ArLoad(arLoad), .AddrSel(addrSel),
        .DirectAddress(directAddress), .MemWrite(memWrite)
    );

    registerFile #(.DataWidth(DataWidth)) regFile (
        .Clock(Clock), .Reset(Reset), .RfWrite(rfWrite), .RfMode(rfMode),
        .RfSource(rfSource), .AluResult(aluResult), .MemData(memData),
        .Immediate(immediate), .ReadSelA(readSelA), .ReadSelB(readSelB),
        .OutA(outA), .OutB(outB)
    );

    addressRegisters addrRegs (
        .Clock(Clock), .Reset(Reset), .PcIncrement(pcIncrement), .PcLoad(pcLoad),
        .ArLoad(arLoad), .LoadValue(aluResult[AddressWidth-1:0]), .AddrSel(addrSel),
        .DirectAddress(directAddress), .MemAddress(memAddress)
    );

    arithmeticUnit #(.DataWidth(DataWidth)) alu (
        .Clock(Clock), .Reset(Reset), .AluOp(aluOp), .WriteFlags(writeFlags),
        .OperandA(outA), .OperandB(outB), .Result(aluResult), .Zero(zero)
    );

    programMemory memory (
        .Clock(Clock), .MemAddress(memAddress), .WriteData(outA[ByteWidth-1:0]),
        .MemWrite(memWrite), .ReadData(memData), .LoadWrite(LoadWrite),
        .LoadAddress(LoadAddress), .LoadData(LoadData), .LoadReadData(LoadReadData)
    );

endmodule

//--- logic/programMemory.sv
`timescale 1ns/1ps

module programMemory (
    input  logic            Clock,
    input  cpuPkg::addressT MemAddress,
    input  cpuPkg::byteT    WriteData,
    input  logic            MemWrite,
    output cpuPkg::byteT    ReadData,
    input  logic            LoadWrite,
    input  cpuPkg::addressT LoadAddress,
    input  cpuPkg::byteT    LoadData,
    output cpuPkg::byteT    LoadReadData
);
    import cpuPkg::*;

    localparam int Depth = 2 ** AddressWidth;

    byteT memory [Depth];

    always_ff @(posedge Clock) begin
        if (LoadWrite) begin
            memory[LoadAddress] <= LoadData;  // Load port has priority
        end else if (MemWrite) begin
            memory[MemAddress] <= WriteData;
        end
    end

    assign ReadData = memory[MemAddress];
    assign LoadReadData = memory[LoadAddress];

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int DataWidth = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  cpuPkg::regOneHotT    RfWrite,
    input  cpuPkg::rfModeE       RfMode,
    input  cpuPkg::rfSourceE     RfSource,
    input  logic [DataWidth-1:0] AluResult,
    input  cpuPkg::byteT         MemData,
    input  cpuPkg::byteT         Immediate,
    input  logic [1:0]           ReadSelA,
    input  logic [1:0]           ReadSelB,
    output logic [DataWidth-1:0] OutA,
    output logic [DataWidth-1:0] OutB
);
    import cpuPkg::*;

    localparam logic [DataWidth-1:0] LowMask = DataWidth'({ByteWidth{1'b1}});

    logic [DataWidth-1:0] registers [4];  // R1 to R4
    logic [DataWidth-1:0] writeValue;

    always_comb begin
        case (RfSource)
            cpuPkg::MemoryByte: writeValue = DataWidth'(MemData);  // Zero extended
            cpuPkg::Immediate:  writeValue = DataWidth'(Immediate);
            default:            writeValue = AluResult;
        endcase
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            for (int i = 0; i < 4; i++) begin
                registers[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (RfWrite[i] && RfMode == LoadLow) begin
                    registers[i] <= (registers[i] & ~LowMask) | (writeValue & LowMask);
                end else if (RfWrite[i]) begin
                    registers[i] <= writeValue;
                end
            end
        end
    end

    assign OutA = registers[ReadSelA];
    assign OutB = registers[ReadSelB];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpuSystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuSystemTb -f all.f -o simCpu

output=$(./obj_dir/simCpu)
echo "$output"

if grep -qxF '>>> PASS' <<< "$output"; then
    exit 0
fi
exit 1
